//--- tb.f
design/fetch_pkg.sv
design/ifu.sv
design/icache.sv
design/idu.sv
design/fetch_top.sv
tb/axi_mem_model.sv
tb/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the testbench twice: once from flash, once from SDRAM.
set -u
cd "$(dirname "$0")"

status=0
for start in 30000000 A0000000; do
    obj="obj_${start}"
    log="sim_${start}.log"
    verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top \
        "-GSTART_PC=32'h${start}" --Mdir "${obj}" -o tb_sim
    if [ $? -ne 0 ]; then
        echo "Build failed for start address ${start}"
        exit 1
    fi
    "./${obj}/tb_sim" > "${log}" 2>&1
    rc=$?
    cat "${log}"
    if [ ${rc} -ne 0 ]; then
        echo "Simulation exited with status ${rc}"
        status=1
    fi
    if grep -q "TESTS FAILED" "${log}"; then
        status=1
    elif ! grep -q "TESTS PASSED" "${log}"; then
        echo "Simulation ended without a result"
        status=1
    fi
done
exit ${status}

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top import fetch_pkg::*; #(
    parameter logic [31:0] START_PC = 32'h3000_0000
);

    localparam int T_SEQ = 0, T_DEC = 1, T_JAL = 2, T_REFILL = 3, T_HIT = 4, T_BP = 5;
    localparam int T_FAULT = 6;
    localparam int RETIRE_TARGET = 40;

    logic clk, rst, out_ready;
    logic arready, rvalid, rlast, arvalid, rready, out_valid, access_fault;
    logic [1:0]  rresp, arburst;
    logic [2:0]  arsize;
    logic [3:0]  rid, arid;
    logic [7:0]  arlen;
    logic [31:0] rdata, araddr, out_pc, out_inst, out_imm;
    logic [4:0]  out_rd, out_rs1, out_rs2;
    inst_class_e out_class;

    logic [31:0] image [256];
    logic [31:0] lfsr_state;
    int          errors [7];
    string       test_names [7] = '{"sequential fetch", "decode fields", "jal redirect",
                                    "refill type", "cache hits", "back-pressure", "fault"};
    int          base_refills;
    int          flash_beats;

    fetch_top #(.RESET_PC(START_PC)) dut_i (.*);

    axi_mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    // RV32I immediate rules, straight from the bit layout.
    function automatic logic [31:0] expected_imm(input logic [31:0] w);
        case (w[6:0])
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: return {{20{w[31]}}, w[31:20]};
            OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_JAL:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_LUI, OPC_AUIPC: return {w[31:12], 12'd0};
            default:    return 32'd0;
        endcase
    endfunction

    function automatic inst_class_e expected_class(input logic [31:0] w);
        case (w[6:0])
            OPC_OP:     return CLASS_ALU_REG;
            OPC_OP_IMM: return CLASS_ALU_IMM;
            OPC_LOAD:   return CLASS_LOAD;
            OPC_STORE:  return CLASS_STORE;
            OPC_BRANCH: return CLASS_BRANCH;
            OPC_JAL:    return CLASS_JAL;
            OPC_JALR:   return CLASS_JALR;
            OPC_LUI, OPC_AUIPC: return CLASS_LUI_AUIPC;
            default:    return CLASS_ILLEGAL;
        endcase
    endfunction

    task automatic check_value(input int test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) else begin
            errors[test]++;
            $display("Error %s (%s): expected %h, actual %h",
                     test_names[test], what, expected, actual);
        end
    endtask

    task automatic report_failure(input int test, input string msg);
        errors[test]++;
        $display("%s: %s", test_names[test], msg);
    endtask

    // AR monitor, sampled before the edge updates the DUT.
    always @(posedge clk) begin
        if (!rst && arvalid && arready) begin
            if (araddr == START_PC) begin
                base_refills++;
            end
            if (araddr[31:28] == REGION_SDRAM_LO || araddr[31:28] == REGION_SDRAM_HI) begin
                check_value(T_REFILL, "burst base", 32'd0, 32'(araddr[3:0]));
            end else begin
                // Single beats walk the line from its base, one word each.
                check_value(T_REFILL, "beat address", 32'((flash_beats % 4) * 4),
                            32'(araddr[3:0]));
                flash_beats++;
            end
        end
    end

    initial begin
        logic [31:0] exp_pc, jal_target, hold_pc, hold_inst, hold_imm;
        logic        prev_jal, stalled, b0, b1;
        int          retired, cycles, base_retires, fault_retires, failed;
        rst          = 1'b1;
        out_ready    = 1'b0;
        lfsr_state   = 32'he7f67ddd;
        base_refills = 0;
        flash_beats  = 0;
        foreach (errors[i]) begin
            errors[i] = 0;
        end
        // Unused words are addi x0, x0, index.
        for (int i = 0; i < 256; i++) begin
            image[i] = 32'h0000_0013 | (32'(i) << 20);
        end
        image[0]   = 32'h0050_0093;
        image[1]   = 32'h0020_81B3;
        image[2]   = 32'hFF81_2203;
        image[3]   = 32'h0053_2623;
        image[4]   = 32'h0020_8863;
        image[5]   = 32'h1234_53B7;
        image[6]   = 32'h0000_8067;
        image[7]   = 32'hFFFF_FFFF;
        image[8]   = 32'h0080_00EF;
        image[10]  = 32'hFCDF_F06F;
        // Mid-line just below the start line, jumps back to the start.
        image[253] = 32'h00C0_006F;
        for (int i = 0; i < 256; i++) begin
            mem_i.flash[i] = image[i];
            mem_i.sdram[i] = image[i];
        end
        exp_pc        = START_PC;
        prev_jal      = 1'b0;
        stalled       = 1'b0;
        retired       = 0;
        cycles        = 0;
        base_retires  = 0;
        fault_retires = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        while (retired < RETIRE_TARGET && cycles < 4000) begin
            @(negedge clk);
            cycles++;
            if (stalled) begin
                check_value(T_BP, "valid", 32'd1, 32'(out_valid));
                check_value(T_BP, "pc", hold_pc, out_pc);
                check_value(T_BP, "inst", hold_inst, out_inst);
                check_value(T_BP, "imm", hold_imm, out_imm);
            end
            take_bit(b0);
            take_bit(b1);
            out_ready = b0 | b1;
            stalled   = out_valid && !out_ready;
            hold_pc   = out_pc;
            hold_inst = out_inst;
            hold_imm  = out_imm;
            if (out_valid && out_ready) begin
                retired++;
                check_value(T_SEQ, "pc", exp_pc, out_pc);
                check_value(T_SEQ, "inst", image[exp_pc[9:2]], out_inst);
                if (prev_jal) begin
                    check_value(T_JAL, "target", jal_target, out_pc);
                end
                check_value(T_DEC, "class", 32'(expected_class(out_inst)), 32'(out_class));
                check_value(T_DEC, "rd", 32'(out_inst[11:7]), 32'(out_rd));
                check_value(T_DEC, "rs1", 32'(out_inst[19:15]), 32'(out_rs1));
                check_value(T_DEC, "rs2", 32'(out_inst[24:20]), 32'(out_rs2));
                check_value(T_DEC, "imm", expected_imm(out_inst), out_imm);
                if (out_pc[31:28] == 4'h2) begin
                    fault_retires++;
                    check_value(T_FAULT, "access_fault", 32'd1, 32'(access_fault));
                end
                if (out_pc == START_PC) begin
                    base_retires++;
                end
                prev_jal   = (out_inst[6:0] == OPC_JAL);
                jal_target = exp_pc + expected_imm(image[exp_pc[9:2]]);
                exp_pc     = prev_jal ? jal_target : exp_pc + 32'd4;
            end
        end
        if (retired < RETIRE_TARGET) begin
            $display("Timeout: only %0d of %0d instructions retired", retired, RETIRE_TARGET);
            $display("TESTS FAILED");
            $finish;
        end else begin
            check_value(T_REFILL, "bad requests", 32'd0, 32'(mem_i.bad_requests));
            if (mem_i.hang) begin
                report_failure(T_REFILL, "read data was never accepted by the DUT");
            end
            check_value(T_HIT, "start line refills", 32'd1, 32'(base_refills));
            if (base_retires < 2) begin
                report_failure(T_HIT, "start line was not executed a second time");
            end
            if (START_PC[31:28] == 4'h3 && fault_retires == 0) begin
                report_failure(T_FAULT, "no instruction from the fault region retired");
            end
            failed = 0;
            foreach (errors[i]) begin
                $display("Test %s: %s (%0d errors)", test_names[i],
                         (errors[i] == 0) ? "ok" : "bad", errors[i]);
                if (errors[i] != 0) begin
                    failed++;
                end
            end
            $display("%0d tests, %0d passed, %0d failed", 7, 7 - failed, failed);
            if (failed == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model import fetch_pkg::*; #(
    parameter int BLOCK_SIZE = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    input  logic [31:0] araddr,
    input  logic [3:0]  arid,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,
    input  logic        rready,
    output logic        arready,
    output logic        rvalid,
    output logic [1:0]  rresp,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic [3:0]  rid
);

    logic [31:0] flash [256];
    logic [31:0] sdram [256];
    logic [31:0] lfsr_state;
    int          bad_requests;
    logic        hang;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic in_sdram(input logic [31:0] addr);
        return (addr[31:28] == REGION_SDRAM_LO) || (addr[31:28] == REGION_SDRAM_HI);
    endfunction

    // Random stall of 0 to 3 cycles.
    task automatic pause();
        logic [1:0] n;
        n[0] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        n[1] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        logic [31:0] addr;
        logic [7:0]  len;
        logic        burst_req;
        int          wait_cycles;
        arready      = 1'b0;
        rvalid       = 1'b0;
        rresp        = 2'b00;
        rdata        = 32'd0;
        rlast        = 1'b0;
        rid          = 4'd0;
        bad_requests = 0;
        hang         = 1'b0;
        lfsr_state   = 32'he7f67ddd;
        forever begin
            @(negedge clk);
            if (!rst && arvalid) begin
                pause();
                arready   = 1'b1;
                addr      = araddr;
                len       = arlen;
                burst_req = in_sdram(araddr);
                if (burst_req && (arlen != 8'(BLOCK_SIZE / 4 - 1) || arburst != 2'b01)) begin
                    bad_requests++;
                end
                if (!burst_req && (arlen != 8'd0 || arburst != 2'b00)) begin
                    bad_requests++;
                end
                // Every request carries ID 0 and word size.
                if (arid != 4'd0 || arsize != 3'b010) begin
                    bad_requests++;
                end
                @(negedge clk);
                arready = 1'b0;
                for (int i = 0; i <= int'(len); i++) begin
                    pause();
                    rvalid = 1'b1;
                    rlast  = (i == int'(len));
                    // Fault region returns the aliased flash word with SLVERR.
                    rresp  = (addr[31:28] == 4'h2) ? 2'b10 : 2'b00;
                    if (burst_req) begin
                        rdata = sdram[8'((addr >> 2) + 32'(i))];
                    end else begin
                        rdata = flash[addr[9:2]];
                    end
                    wait_cycles = 0;
                    while (!rready && wait_cycles < 100) begin
                        @(negedge clk);
                        wait_cycles++;
                    end
                    if (!rready) begin
                        hang = 1'b1;
                    end
                    @(negedge clk);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int          BLOCK_SIZE = 16,
    parameter int          LINES      = 16,
    parameter logic [31:0] RESET_PC   = 32'h3000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        arready,
    input  logic        rvalid,
    input  logic [1:0]  rresp,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic [3:0]  rid,
    input  logic        out_ready,
    output logic        arvalid,
    output logic [31:0] araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        rready,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output inst_class_e out_class,
    output logic [4:0]  out_rd,
    output logic [4:0]  out_rs1,
    output logic [4:0]  out_rs2,
    output logic [31:0] out_imm,
    output logic        access_fault
);

    logic [31:0]             lookup_addr;
    logic                    hit;
    logic [31:0]             hit_data;
    logic                    fill;
    logic [31:0]             fill_addr;
    logic [BLOCK_SIZE*8-1:0] fill_line;
    logic                    fetch_valid;
    logic [31:0]             fetch_pc;
    logic [31:0]             fetch_inst;
    logic                    decode_ready;
    logic                    redirect_valid;
    logic [31:0]             redirect_pc;

    ifu #(
        .BLOCK_SIZE (BLOCK_SIZE),
        .RESET_PC   (RESET_PC)
    ) ifu_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .decode_ready   (decode_ready),
        .hit            (hit),
        .hit_data       (hit_data),
        .arready        (arready),
        .rvalid         (rvalid),
        .rresp          (rresp),
        .rdata          (rdata),
        .rlast          (rlast),
        .rid            (rid),
        .lookup_addr    (lookup_addr),
        .fill           (fill),
        .fill_addr      (fill_addr),
        .fill_line      (fill_line),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .arid           (arid),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .rready         (rready),
        .access_fault   (access_fault)
    );

    icache #(
        .BLOCK_SIZE (BLOCK_SIZE),
        .LINES      (LINES)
    ) icache_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .fill_line   (fill_line),
        .hit         (hit),
        .hit_data    (hit_data)
    );

    idu idu_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst),
        .out_ready      (out_ready),
        .decode_ready   (decode_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_inst       (out_inst),
        .out_class      (out_class),
        .out_rd         (out_rd),
        .out_rs1        (out_rs1),
        .out_rs2        (out_rs2),
        .out_imm        (out_imm)
    );

endmodule

//--- design/idu.sv
`timescale 1ns/1ps

module idu import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_pc,
    input  logic [31:0] fetch_inst,
    input  logic        out_ready,
    output logic        decode_ready,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output inst_class_e out_class,
    output logic [4:0]  out_rd,
    output logic [4:0]  out_rs1,
    output logic [4:0]  out_rs2,
    output logic [31:0] out_imm
);

    logic  take;
    logic  first_cycle;
    inst_u word;

    assign decode_ready = out_ready || !out_valid;

    // The word arriving alongside a redirect follows the JAL and is dropped.
    assign take = fetch_valid && decode_ready && !redirect_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid   <= 1'b0;
            first_cycle <= 1'b0;
        end else begin
            if (decode_ready) begin
                out_valid <= take;
            end
            first_cycle <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_pc   <= fetch_pc;
            out_inst <= fetch_inst;
        end
    end

    assign word    = out_inst;
    assign out_rd  = word.r_fmt.rd;
    assign out_rs1 = word.r_fmt.rs1;
    assign out_rs2 = word.r_fmt.rs2;

    always_comb begin
        out_class = CLASS_ILLEGAL;
        out_imm   = 32'd0;
        case (word.r_fmt.opcode)
            OPC_OP: begin
                out_class = CLASS_ALU_REG;
            end
            OPC_OP_IMM: begin
                out_class = CLASS_ALU_IMM;
                out_imm   = {{20{word.i_fmt.imm_11_0[11]}}, word.i_fmt.imm_11_0};
            end
            OPC_LOAD: begin
                out_class = CLASS_LOAD;
                out_imm   = {{20{word.i_fmt.imm_11_0[11]}}, word.i_fmt.imm_11_0};
            end
            OPC_JALR: begin
                out_class = CLASS_JALR;
                out_imm   = {{20{word.i_fmt.imm_11_0[11]}}, word.i_fmt.imm_11_0};
            end
            OPC_STORE: begin
                out_class = CLASS_STORE;
                out_imm   = {{20{word.s_fmt.imm_11_5[6]}}, word.s_fmt.imm_11_5,
                             word.s_fmt.imm_4_0};
            end
            OPC_BRANCH: begin
                out_class = CLASS_BRANCH;
                out_imm   = {{19{word.b_fmt.imm_12}}, word.b_fmt.imm_12, word.b_fmt.imm_11,
                             word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0};
            end
            OPC_JAL: begin
                out_class = CLASS_JAL;
                out_imm   = {{11{word.j_fmt.imm_20}}, word.j_fmt.imm_20, word.j_fmt.imm_19_12,
                             word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                out_class = CLASS_LUI_AUIPC;
                out_imm   = {word.u_fmt.imm_31_12, 12'd0};
            end
            default: begin
                out_class = CLASS_ILLEGAL;
            end
        endcase
    end

    // Only meaningful for JAL, where out_imm is the J immediate.
    assign redirect_pc    = out_pc + out_imm;
    assign redirect_valid = out_valid && first_cycle && (out_class == CLASS_JAL);

endmodule

//--- design/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int BLOCK_SIZE = 16,
    parameter int LINES      = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [31:0]             lookup_addr,
    input  logic                    fill,
    input  logic [31:0]             fill_addr,
    input  logic [BLOCK_SIZE*8-1:0] fill_line,
    output logic                    hit,
    output logic [31:0]             hit_data
);

    localparam int OFFSET_W = $clog2(BLOCK_SIZE);
    localparam int INDEX_W  = $clog2(LINES);
    localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;
    localparam int LINE_W   = BLOCK_SIZE * 8;

    logic [TAG_W-1:0]    tag_mem  [LINES];
    logic [LINE_W-1:0]   data_mem [LINES];
    logic [LINES-1:0]    valid;

    logic [INDEX_W-1:0]  rd_index;
    logic [TAG_W-1:0]    rd_tag;
    logic [OFFSET_W-1:0] rd_word;
    logic [LINE_W-1:0]   rd_line;
    logic [INDEX_W-1:0]  wr_index;
    logic [TAG_W-1:0]    wr_tag;

    // Address split into tag, index and byte offset.
    assign rd_index = lookup_addr[OFFSET_W +: INDEX_W];
    assign rd_tag   = lookup_addr[31 -: TAG_W];
    assign rd_word  = lookup_addr[OFFSET_W-1:0] >> 2;

    assign wr_index = fill_addr[OFFSET_W +: INDEX_W];
    assign wr_tag   = fill_addr[31 -: TAG_W];

    assign rd_line  = data_mem[rd_index];
    assign hit      = valid[rd_index] && (tag_mem[rd_index] == rd_tag);
    assign hit_data = rd_line[rd_word*32 +: 32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // Whole line written in one edge.
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= fill_line;
        end
    end

endmodule

//--- design/ifu.sv
`timescale 1ns/1ps

module ifu import fetch_pkg::*; #(
    parameter int          BLOCK_SIZE = 16,
    parameter logic [31:0] RESET_PC   = 32'h3000_0000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect_valid,
    input  logic [31:0]             redirect_pc,
    input  logic                    decode_ready,
    input  logic                    hit,
    input  logic [31:0]             hit_data,
    input  logic                    arready,
    input  logic                    rvalid,
    input  logic [1:0]              rresp,
    input  logic [31:0]             rdata,
    input  logic                    rlast,
    input  logic [3:0]              rid,
    output logic [31:0]             lookup_addr,
    output logic                    fill,
    output logic [31:0]             fill_addr,
    output logic [BLOCK_SIZE*8-1:0] fill_line,
    output logic                    fetch_valid,
    output logic [31:0]             fetch_pc,
    output logic [31:0]             fetch_inst,
    output logic                    arvalid,
    output logic [31:0]             araddr,
    output logic [3:0]              arid,
    output logic [7:0]              arlen,
    output logic [2:0]              arsize,
    output logic [1:0]              arburst,
    output logic                    rready,
    output logic                    access_fault
);

    localparam int         OFFSET_W    = $clog2(BLOCK_SIZE);
    localparam int         BEATS       = BLOCK_SIZE / 4;
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [2:0] SIZE_WORD   = 3'b010;

    typedef enum logic {
        ST_IDLE,
        ST_REFILL
    } state_e;

    state_e      state;
    logic [31:0] pc;
    logic [31:0] pc_base;
    logic        pc_sdram;
    logic [31:0] line_base;
    logic        line_sdram;
    logic [2:0]  beat;
    logic        last_beat;
    logic        ar_fire;
    logic        r_fire;
    logic        miss;
    logic        fetch_take;

    assign lookup_addr = pc;
    assign fill_addr   = line_base;
    assign arid        = 4'd0;
    assign arsize      = SIZE_WORD;

    assign pc_base  = {pc[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign pc_sdram = (pc[31:28] == REGION_SDRAM_LO) || (pc[31:28] == REGION_SDRAM_HI);

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // A burst ends on rlast, single beats on the counted last word.
    assign last_beat = line_sdram ? rlast : (beat == 3'(BEATS - 1));

    assign miss       = (state == ST_IDLE) && !hit && !redirect_valid;
    assign fetch_take = (state == ST_IDLE) && hit && decode_ready && !redirect_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            pc           <= RESET_PC;
            fetch_valid  <= 1'b0;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            fill         <= 1'b0;
            access_fault <= 1'b0;
            beat         <= 3'd0;
        end else begin
            fill <= 1'b0;

            // The word in the fetch register is always wrong-path on a redirect.
            if (redirect_valid) begin
                pc          <= redirect_pc;
                fetch_valid <= 1'b0;
            end else if (decode_ready) begin
                fetch_valid <= fetch_take;
                if (fetch_take) begin
                    pc <= pc + 32'd4;
                end
            end

            case (state)
                ST_IDLE: begin
                    if (miss) begin
                        state        <= ST_REFILL;
                        arvalid      <= 1'b1;
                        beat         <= 3'd0;
                        access_fault <= 1'b0;
                    end
                end
                ST_REFILL: begin
                    // Stay here through the fill cycle so the lookup sees the new line.
                    if (fill) begin
                        state <= ST_IDLE;
                    end
                    if (ar_fire) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (r_fire) begin
                        beat <= beat + 3'd1;
                        if ((rresp != 2'b00) || (rid != arid)) begin
                            access_fault <= 1'b1;
                        end
                        if (last_beat) begin
                            rready <= 1'b0;
                            fill   <= 1'b1;
                        end else if (!line_sdram) begin
                            rready  <= 1'b0;
                            arvalid <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_take) begin
            fetch_pc   <= pc;
            fetch_inst <= hit_data;
        end
        if (miss) begin
            line_base  <= pc_base;
            line_sdram <= pc_sdram;
            araddr     <= pc_base;
            arlen      <= pc_sdram ? 8'(BEATS - 1) : 8'd0;
            arburst    <= pc_sdram ? BURST_INCR : BURST_FIXED;
        end
        if ((state == ST_REFILL) && r_fire) begin
            fill_line[beat*32 +: 32] <= rdata;
            // Next single-beat request.
            if (!line_sdram && !last_beat) begin
                araddr <= line_base + 32'({beat + 3'd1, 2'b00});
            end
        end
    end

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

    // RV32I base opcodes.
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Top address nibbles served by SDRAM.
    localparam logic [3:0] REGION_SDRAM_LO = 4'hA;
    localparam logic [3:0] REGION_SDRAM_HI = 4'hB;

    // Instruction class from the opcode.
    typedef enum logic [3:0] {
        CLASS_ALU_REG,
        CLASS_ALU_IMM,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_LUI_AUIPC,
        CLASS_ILLEGAL
    } inst_class_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage
